//--- apb_pkg.sv
// APB address, data, request and response types
`default_nettype none

package apb_pkg;

    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

//--- board_pkg.sv
// board, coordinate, threat level and threat list types
`default_nettype none

`include "gomoku_consts.svh"

package board_pkg;

    typedef logic [1:0] cell_t;        // 0 empty, 1 black, 2 white.
    typedef logic [3:0] coord_t;
    typedef logic [7:0] cell_idx_t;    // y * 15 + x.
    typedef logic [1:0] level_t;       // none, open three, four, five.
    typedef logic [3:0] count_t;

    typedef cell_t [`BOARD_CELLS-1:0] board_t;

    // field order follows the threat register layout.
    typedef struct packed {
        logic   side;                  // 1 for the defend pass.
        level_t level;
        coord_t y;
        coord_t x;
    } threat_t;

    typedef threat_t [`MAX_THREATS-1:0] threat_list_t;

endpackage

`default_nettype wire

//--- board_store.sv
// board register with single cell write port and clear
`timescale 1ns/1ns
`default_nettype none

`include "gomoku_consts.svh"

module board_store (
    input  wire logic                 i_clk,
    input  wire logic                 i_rst_n,
    input  wire logic                 i_wr,
    input  wire board_pkg::cell_idx_t i_wr_idx,
    input  wire board_pkg::cell_t     i_wr_cell,
    input  wire logic                 i_clear,
    output board_pkg::board_t         o_board
);

    import board_pkg::*;

    board_t board_r;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n || i_clear) begin
            board_r <= '0;                    // all cells empty.
        end
        else if (i_wr) begin
            board_r[i_wr_idx] <= i_wr_cell;
        end
    end

    assign o_board = board_r;

    // the register front end filters bad indexes before they get here.
    a_wr_idx_in_range: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_wr |-> (i_wr_idx < `BOARD_CELLS)
    );

endmodule

`default_nettype wire

//--- build.f
apb_pkg.sv
board_pkg.sv
board_store.sv
threat_classifier.sv
threat_scanner.sv
gomoku_apb_regs.sv
gomoku_top.sv
tb_gomoku_top.sv
+incdir+.

//--- gomoku_apb_regs.sv
// APB register front end for control, cell writes, status and threat list
`timescale 1ns/1ns
`default_nettype none

`include "gomoku_consts.svh"

module gomoku_apb_regs (
    input  wire logic                    i_clk,
    input  wire logic                    i_rst_n,
    input  wire apb_pkg::apb_req_t       i_apb,
    output apb_pkg::apb_rsp_t            o_apb,
    output logic                         o_cell_wr,
    output board_pkg::cell_idx_t         o_cell_idx,
    output board_pkg::cell_t             o_cell_val,
    output logic                         o_clear,
    output logic                         o_start,
    output logic                         o_turn,
    input  wire logic                    i_busy,
    input  wire logic                    i_finish,
    input  wire board_pkg::count_t       i_count,
    input  wire logic [1:0]              i_win,
    input  wire board_pkg::threat_list_t i_list
);

    import apb_pkg::*;
    import board_pkg::*;

    logic       wr_access;
    logic       ctrl_wr;
    logic       cell_wr;
    logic       idx_bad;
    logic       ctrl_bad;
    logic       slverr;
    logic       done_r;
    apb_addr_t  thr_off;
    logic [2:0] thr_k;
    logic       thr_hit;
    apb_data_t  rdata;

    assign wr_access = i_apb.psel && i_apb.penable && i_apb.pwrite;
    assign ctrl_wr   = wr_access && (i_apb.paddr == `REG_CTRL);
    assign cell_wr   = wr_access && (i_apb.paddr == `REG_CELL);

    assign o_cell_idx = cell_idx_t'(i_apb.pwdata[7:0]);
    assign o_cell_val = cell_t'(i_apb.pwdata[`CELL_VAL_LSB +: 2]);
    assign idx_bad    = (o_cell_idx >= `BOARD_CELLS);
    assign ctrl_bad   = i_busy && (i_apb.pwdata[`CTRL_START] || i_apb.pwdata[`CTRL_CLEAR]);

    assign o_cell_wr = cell_wr && !i_busy && !idx_bad;
    assign o_start   = ctrl_wr && !i_busy && i_apb.pwdata[`CTRL_START];
    assign o_clear   = ctrl_wr && !i_busy && i_apb.pwdata[`CTRL_CLEAR];
    assign o_turn    = i_apb.pwdata[`CTRL_TURN];   // only sampled with start.
    assign slverr    = (cell_wr && (i_busy || idx_bad)) || (ctrl_wr && ctrl_bad);

    // done stays up until the next accepted start.
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) done_r <= 1'b0;
        else if (o_start) done_r <= 1'b0;
        else if (i_finish) done_r <= 1'b1;
    end

    assign thr_off = i_apb.paddr - `REG_THREAT_BASE;
    assign thr_k   = thr_off[4:2];
    assign thr_hit = (i_apb.paddr >= `REG_THREAT_BASE) && (thr_off[7:2] < `MAX_THREATS)
                  && (thr_off[1:0] == 2'b00);

    always_comb begin
        rdata = '0;
        if (i_apb.paddr == `REG_STATUS) begin
            rdata[`STAT_BUSY]           = i_busy;
            rdata[`STAT_DONE]           = done_r;
            rdata[`STAT_COUNT_LSB +: 4] = i_count;
            rdata[`STAT_WIN_LSB +: 2]   = i_win;
        end
        else if (thr_hit && ({1'b0, thr_k} < i_count)) begin
            rdata[$bits(threat_t)-1:0] = i_list[thr_k];  // unused entries read 0.
        end
    end

    assign o_apb = '{prdata: rdata, pready: 1'b1, pslverr: slverr};

    a_penable_with_psel: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_apb.penable |-> i_apb.psel
    );

endmodule

`default_nettype wire

//--- gomoku_consts.svh
// board size, threat list depth, cell and level codes, register map and field positions
`ifndef GOMOKU_CONSTS_SVH
`define GOMOKU_CONSTS_SVH

`define BOARD_DIM        15
`define BOARD_CELLS      225
`define MAX_THREATS      8

`define CELL_BLACK       2'd1
`define CELL_WHITE       2'd2

`define LVL_NONE         2'd0
`define LVL_THREE        2'd1
`define LVL_FOUR         2'd2
`define LVL_FIVE         2'd3

`define REG_CTRL         8'h00
`define REG_CELL         8'h04
`define REG_STATUS       8'h08
`define REG_THREAT_BASE  8'h40

`define CTRL_START       0
`define CTRL_TURN        1
`define CTRL_CLEAR       2
`define CELL_VAL_LSB     8
`define STAT_BUSY        0
`define STAT_DONE        1
`define STAT_COUNT_LSB   4
`define STAT_WIN_LSB     8

`endif

//--- gomoku_top.sv
// top level with APB front end, board store and threat scanner
`timescale 1ns/1ns
`default_nettype none

module gomoku_top (
    input  wire logic              i_clk,
    input  wire logic              i_rst_n,
    input  wire apb_pkg::apb_req_t i_apb,
    output apb_pkg::apb_rsp_t      o_apb
);

    import board_pkg::*;

    logic         cell_wr;
    cell_idx_t    cell_idx;
    cell_t        cell_val;
    logic         clear;
    logic         start;
    logic         turn;
    logic         busy;
    logic         finish;
    count_t       count;
    logic [1:0]   win;
    threat_list_t list;
    board_t       board;

    gomoku_apb_regs u_regs (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_apb      (i_apb),
        .o_apb      (o_apb),
        .o_cell_wr  (cell_wr),
        .o_cell_idx (cell_idx),
        .o_cell_val (cell_val),
        .o_clear    (clear),
        .o_start    (start),
        .o_turn     (turn),
        .i_busy     (busy),
        .i_finish   (finish),
        .i_count    (count),
        .i_win      (win),
        .i_list     (list)
    );

    board_store u_board (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_wr      (cell_wr),
        .i_wr_idx  (cell_idx),
        .i_wr_cell (cell_val),
        .i_clear   (clear),
        .o_board   (board)
    );

    threat_scanner u_scanner (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_start  (start),
        .i_turn   (turn),
        .i_board  (board),
        .o_busy   (busy),
        .o_finish (finish),
        .o_count  (count),
        .o_win    (win),
        .o_list   (list)
    );

endmodule

`default_nettype wire

//--- tb_gomoku_top.sv
// testbench for gomoku_top with reference threat model, APB tasks and compare tasks
`timescale 1ns/1ns
`default_nettype none

`include "gomoku_consts.svh"

module tb_gomoku_top;

    import board_pkg::*;
    import apb_pkg::*;

    logic     clk;
    logic     rst_n;
    apb_req_t req;
    apb_rsp_t rsp;
    board_t   model;                      // host-side copy of the board.

    gomoku_top dut (
        .i_clk   (clk),
        .i_rst_n (rst_n),
        .i_apb   (req),
        .o_apb   (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("ERRORS FOUND");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_status(input string name, input apb_data_t exp, input apb_data_t act);
        if (act !== exp)
            stop_on_error($sformatf("[FAIL] %s expected %08h actual %08h", name, exp, act));
    endtask

    task automatic check_threat(input string name, input threat_t exp, input threat_t act);
        if (act !== exp)
            stop_on_error($sformatf("[FAIL] %s expected %03h actual %03h", name, exp, act));
    endtask

    task automatic check_resp(input string name, input logic exp, input logic act);
        if (act !== exp)
            stop_on_error($sformatf("[FAIL] %s pslverr expected %0b actual %0b", name, exp, act));
    endtask

    // setup at +2 ns, access one cycle later, response taken at the falling edge.
    task automatic apb_transfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                                output apb_data_t rdata, output logic err);
        int waited;
        req.psel    = 1'b1;
        req.penable = 1'b0;
        req.pwrite  = wr;
        req.paddr   = addr;
        req.pwdata  = wdata;
        @(posedge clk);
        #2 req.penable = 1'b1;
        waited = 0;
        @(negedge clk);
        while (!rsp.pready) begin
            waited++;
            if (waited > 16) stop_on_error("APB transfer never saw pready");
            @(negedge clk);
        end
        rdata = rsp.prdata;
        err   = rsp.pslverr;
        @(posedge clk);
        #2 req.psel = 1'b0;
        req.penable = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
        apb_data_t unused;
        apb_transfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
        logic err;
        apb_transfer(1'b0, addr, '0, data, err);
    endtask

    // -1 marks a position off the board.
    function automatic int cell_or_wall(input board_t b, input int x, input int y);
        if (x < 0 || x >= `BOARD_DIM || y < 0 || y >= `BOARD_DIM) return -1;
        return int'(b[y * `BOARD_DIM + x]);
    endfunction

    function automatic logic is_empty(input board_t b, input int x, input int y);
        int v;
        v = cell_or_wall(b, x, y);
        return (v == 0) || (v == 3);
    endfunction

    function automatic level_t ref_level(input board_t b, input int x, input int y,
                                         input cell_t c);
        level_t best;
        int     d;
        int     s;
        int     dx;
        int     dy;
        int     fx;
        int     fy;
        int     bx;
        int     by;
        int     run;
        best = `LVL_NONE;
        if (!is_empty(b, x, y)) return `LVL_NONE;
        for (d = 0; d < 4; d++) begin
            dx  = (d == 1) ? 0 : 1;
            dy  = (d == 0) ? 0 : ((d == 3) ? -1 : 1);
            run = 1;
            fx  = x + dx;
            fy  = y + dy;
            for (s = 0; s < 4 && cell_or_wall(b, fx, fy) == int'(c); s++) begin
                fx  += dx;
                fy  += dy;
                run++;
            end
            bx = x - dx;
            by = y - dy;
            for (s = 0; s < 4 && cell_or_wall(b, bx, by) == int'(c); s++) begin
                bx  -= dx;
                by  -= dy;
                run++;
            end
            if (run >= 5) best = `LVL_FIVE;
            else if (run == 4 && best < `LVL_FOUR) best = `LVL_FOUR;
            else if (run == 3 && is_empty(b, fx, fy) && is_empty(b, bx, by) && best == `LVL_NONE)
                best = `LVL_THREE;
        end
        return best;
    endfunction

    // attack pass for the side to move, then defend pass for the opponent.
    function automatic void ref_scan(input board_t b, input logic turn, output threat_list_t list,
                                     output count_t count, output logic [1:0] win);
        threat_t t;
        cell_t   c;
        level_t  lvl;
        int      side;
        int      idx;
        list  = '0;
        count = '0;
        win   = '0;
        for (side = 0; side < 2; side++) begin
            if (side == 0) c = turn ? `CELL_WHITE : `CELL_BLACK;
            else c = turn ? `CELL_BLACK : `CELL_WHITE;
            for (idx = 0; idx < `BOARD_CELLS; idx++) begin
                lvl = ref_level(b, idx % `BOARD_DIM, idx / `BOARD_DIM, c);
                if (lvl != `LVL_NONE && count < `MAX_THREATS) begin
                    t.x         = coord_t'(idx % `BOARD_DIM);
                    t.y         = coord_t'(idx / `BOARD_DIM);
                    t.level     = lvl;
                    t.side      = side[0];
                    list[count] = t;
                    count++;
                end
                if (lvl == `LVL_FIVE) win[side] = 1'b1;
            end
        end
    endfunction

    task automatic place(input int idx, input cell_t val);
        logic err;
        apb_write(`REG_CELL, apb_data_t'({val, 8'(idx)}), err);
        check_resp($sformatf("cell write %0d", idx), 1'b0, err);
        model[idx] = val;
    endtask

    task automatic clear_board();
        logic err;
        apb_write(`REG_CTRL, 32'h4, err);
        check_resp("clear", 1'b0, err);
        model = '0;
    endtask

    task automatic start_scan(input logic turn);
        logic err;
        apb_write(`REG_CTRL, apb_data_t'({turn, 1'b1}), err);
        check_resp("start", 1'b0, err);
    endtask

    task automatic wait_done();
        apb_data_t rd;
        int        cycles;
        cycles = 0;
        apb_read(`REG_STATUS, rd);
        while (!rd[`STAT_DONE]) begin
            cycles += 2;                  // one status read per two cycles.
            if (cycles > 1000) stop_on_error("scan did not report done within 1000 cycles");
            apb_read(`REG_STATUS, rd);
        end
    endtask

    task automatic compare_results(input string name, input logic turn);
        threat_list_t exp_list;
        count_t       exp_count;
        logic [1:0]   exp_win;
        apb_data_t    exp_stat;
        apb_data_t    rd;
        int           k;
        ref_scan(model, turn, exp_list, exp_count, exp_win);
        exp_stat                        = '0;
        exp_stat[`STAT_DONE]            = 1'b1;
        exp_stat[`STAT_COUNT_LSB +: 4]  = exp_count;
        exp_stat[`STAT_WIN_LSB +: 2]    = exp_win;
        apb_read(`REG_STATUS, rd);
        check_status({name, " status"}, exp_stat, rd);
        for (k = 0; k < `MAX_THREATS; k++) begin
            apb_read(`REG_THREAT_BASE + 8'(4 * k), rd);
            check_threat($sformatf("%s entry %0d", name, k), exp_list[k], threat_t'(rd[10:0]));
            check_status($sformatf("%s entry %0d upper bits", name, k), '0, {rd[31:11], 11'd0});
        end
    endtask

    task automatic scan(input string name, input logic turn);
        start_scan(turn);
        wait_done();
        compare_results(name, turn);
    endtask

    initial begin
        logic      err;
        apb_data_t rd;
        int        n;
        int        k;
        void'($urandom(8));
        req   = '0;
        rst_n = 1'b0;
        model = '0;
        repeat (4) @(posedge clk);
        #2 rst_n = 1'b1;

        apb_read(`REG_STATUS, rd);
        check_status("reset status", '0, rd);
        scan("empty board", 1'b0);

        place(7 * `BOARD_DIM + 6, `CELL_BLACK);   // open two in row 7.
        place(7 * `BOARD_DIM + 7, `CELL_BLACK);
        scan("open two", 1'b0);

        clear_board();
        for (k = 0; k < 4; k++) place(7 * `BOARD_DIM + 5 + k, `CELL_BLACK);
        scan("four black to move", 1'b0);
        scan("four white to move", 1'b1);

        for (n = 0; n < 6; n++) begin
            clear_board();
            for (k = 0; k < 40; k++) place($urandom % `BOARD_CELLS, cell_t'(($urandom % 2) + 1));
            scan($sformatf("random %0d black", n), 1'b0);
            scan($sformatf("random %0d white", n), 1'b1);
        end

        // writes during a scan must bounce without touching the result.
        start_scan(1'b0);
        apb_read(`REG_STATUS, rd);
        check_status("busy and done during scan", 32'h1, rd & 32'h3);
        apb_write(`REG_CELL, 32'h100, err);
        check_resp("cell write while busy", 1'b1, err);
        apb_write(`REG_CTRL, 32'h3, err);
        check_resp("start while busy", 1'b1, err);
        apb_write(`REG_CTRL, 32'h4, err);
        check_resp("clear while busy", 1'b1, err);
        wait_done();
        compare_results("busy writes", 1'b0);

        apb_write(`REG_CELL, apb_data_t'({`CELL_BLACK, 8'd230}), err);
        check_resp("cell index 230", 1'b1, err);
        clear_board();
        scan("after clear", 1'b0);

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

//--- threat_classifier.sv
// combinational threat level of one empty cell from runs in four directions
`timescale 1ns/1ns
`default_nettype none

`include "gomoku_consts.svh"

module threat_classifier (
    input  wire board_pkg::board_t i_board,
    input  wire board_pkg::coord_t i_x,
    input  wire board_pkg::coord_t i_y,
    input  wire board_pkg::cell_t  i_colour,
    output board_pkg::level_t      o_level
);

    import board_pkg::*;

    // row, column, diagonal and anti-diagonal.
    localparam int DX [4] = '{1, 0, 1, 1};
    localparam int DY [4] = '{0, 1, 1, -1};

    function automatic logic on_board(input int px, input int py);
        return (px >= 0) && (px < `BOARD_DIM) && (py >= 0) && (py < `BOARD_DIM);
    endfunction

    function automatic cell_t cell_at(input int px, input int py);
        return i_board[cell_idx_t'(py * `BOARD_DIM + px)];
    endfunction

    function automatic logic is_colour(input int px, input int py);
        return on_board(px, py) && (cell_at(px, py) == i_colour);
    endfunction

    // value 3 counts as empty as well.
    function automatic logic is_open(input int px, input int py);
        return on_board(px, py) && (cell_at(px, py) != `CELL_BLACK)
            && (cell_at(px, py) != `CELL_WHITE);
    endfunction

    always_comb begin
        int     cx;
        int     cy;
        int     fwd;
        int     bwd;
        int     run;
        logic   go_f;
        logic   go_b;
        logic   open_f;
        logic   open_b;
        level_t lvl;
        level_t best;
        cx   = int'(i_x);
        cy   = int'(i_y);
        best = `LVL_NONE;
        for (int d = 0; d < 4; d++) begin
            fwd  = 0;
            bwd  = 0;
            go_f = 1'b1;
            go_b = 1'b1;
            for (int k = 1; k <= 4; k++) begin
                if (go_f && is_colour(cx + k * DX[d], cy + k * DY[d])) fwd++;
                else go_f = 1'b0;
                if (go_b && is_colour(cx - k * DX[d], cy - k * DY[d])) bwd++;
                else go_b = 1'b0;
            end
            open_f = is_open(cx + (fwd + 1) * DX[d], cy + (fwd + 1) * DY[d]);
            open_b = is_open(cx - (bwd + 1) * DX[d], cy - (bwd + 1) * DY[d]);
            run    = 1 + fwd + bwd;               // stone placed on the cell itself.
            if (run >= 5)                       lvl = `LVL_FIVE;
            else if (run == 4)                  lvl = `LVL_FOUR;
            else if (run == 3 && open_f && open_b) lvl = `LVL_THREE;
            else                                lvl = `LVL_NONE;
            if (lvl > best) best = lvl;
        end
        if (!is_open(cx, cy)) best = `LVL_NONE;  // occupied cell.
        o_level = best;
    end

endmodule

`default_nettype wire

//--- threat_scanner.sv
// attack and defend scan FSM that walks the board and collects threats
`timescale 1ns/1ns
`default_nettype none

`include "gomoku_consts.svh"

module threat_scanner (
    input  wire logic                    i_clk,
    input  wire logic                    i_rst_n,
    input  wire logic                    i_start,
    input  wire logic                    i_turn,
    input  wire board_pkg::board_t       i_board,
    output logic                         o_busy,
    output logic                         o_finish,
    output board_pkg::count_t            o_count,
    output logic [1:0]                   o_win,
    output board_pkg::threat_list_t      o_list
);

    import board_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_ATTACK, S_DEFEND} state_t;

    state_t       state_r, state_w;
    coord_t       x_r, x_w;
    coord_t       y_r, y_w;
    logic         turn_r, turn_w;
    count_t       count_r, count_w;
    logic [1:0]   win_r, win_w;
    logic         finish_r, finish_w;
    threat_list_t list_r, list_w;
    cell_t        colour;
    level_t       level;
    threat_t      entry;

    // side to move on attack, opponent on defend.
    assign colour = ((state_r == S_ATTACK) ^ turn_r) ? `CELL_BLACK : `CELL_WHITE;

    threat_classifier u_classifier (
        .i_board  (i_board),
        .i_x      (x_r),
        .i_y      (y_r),
        .i_colour (colour),
        .o_level  (level)
    );

    always_comb begin
        state_w     = state_r;
        x_w         = x_r;
        y_w         = y_r;
        turn_w      = turn_r;
        count_w     = count_r;
        win_w       = win_r;
        list_w      = list_r;
        finish_w    = 1'b0;
        entry.x     = x_r;
        entry.y     = y_r;
        entry.level = level;
        entry.side  = (state_r == S_DEFEND);
        case (state_r)
            S_IDLE: begin
                if (i_start) begin
                    state_w = S_ATTACK;
                    x_w     = '0;
                    y_w     = '0;
                    turn_w  = i_turn;
                    count_w = '0;
                    win_w   = '0;
                end
            end
            default: begin
                if (level != `LVL_NONE && count_r < `MAX_THREATS) begin
                    list_w[count_r[2:0]] = entry;
                    count_w              = count_r + 1'b1;
                end
                if (level == `LVL_FIVE) win_w[entry.side] = 1'b1;  // kept even when full.
                if (x_r == `BOARD_DIM - 1) begin
                    x_w = '0;
                    if (y_r == `BOARD_DIM - 1) begin
                        y_w = '0;
                        if (state_r == S_ATTACK) begin
                            state_w = S_DEFEND;
                        end
                        else begin
                            state_w  = S_IDLE;
                            finish_w = 1'b1;
                        end
                    end
                    else begin
                        y_w = y_r + 1'b1;
                    end
                end
                else begin
                    x_w = x_r + 1'b1;
                end
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_r  <= S_IDLE;
            x_r      <= '0;
            y_r      <= '0;
            turn_r   <= 1'b0;
            count_r  <= '0;
            win_r    <= '0;
            finish_r <= 1'b0;
        end
        else begin
            state_r  <= state_w;
            x_r      <= x_w;
            y_r      <= y_w;
            turn_r   <= turn_w;
            count_r  <= count_w;
            win_r    <= win_w;
            finish_r <= finish_w;
        end
    end

    always_ff @(posedge i_clk) begin
        list_r <= list_w;
    end

    assign o_busy   = (state_r != S_IDLE);
    assign o_finish = finish_r;
    assign o_count  = count_r;
    assign o_win    = win_r;
    assign o_list   = list_r;

    a_count_max: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        count_r <= `MAX_THREATS
    );

endmodule

`default_nettype wire
